// ==== compile.f ====
+incdir+tb
common/ctrlPkg.sv
logic/instrDecoder.sv
logic/irqArbiter.sv
control/stepSequencer.sv
control/controlWordGen.sv
control/controlUnit.sv
tb/controlUnit_sva.sv
tb/controlUnit_tb.sv

// ==== tb/controlUnit_tests.svh ====
`ifndef CONTROLUNIT_TESTS_SVH
`define CONTROLUNIT_TESTS_SVH

// **************************************************
// start delay followed by one fetch pulse
task automatic testStartDelay();
    int i;
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;
    #1;
    for (i = 0; i < startDelay; i++) begin
        checkStep(1'b0, 1'b0, 1'b0, 1'b0);
        checkValue("irqClr", 0, irqClr);
        checkValue("flagEnable", 1, ctrl.flagEnable);
        checkValue("statusSrc", ctrlPkg::statIrqOff, ctrl.statusSrc);   // irqs held off
        holdCycle();
    end
    checkValue("pcWriteEn", 1, ctrl.pcWriteEn);     // first fetch
endtask

task automatic testAluOps();
    ctrlPkg::instr_t word;
    logic [15:0]     r;
    logic [3:0]      mode;
    int              n;
    for (n = 0; n < 16; n++) begin
        r = lcgNext();
        if (n < 7) begin                    // every imm8 op 1..7
            mode = 4'(n + 1);
            word = {r[15:4], mode};
        end else if (n < 15) begin          // reg-reg with selector 1..9
            word = {r[15:8], 4'(1 + r[3:0] % 9), 4'hA};
            mode = word[6:3];
        end else begin
            word = 16'h358A;                // MOV
            mode = word[6:3];
        end
        applyInputs(word, randFlags(), '0);
        checkStep(1'b1, 1'b0, 1'b0, 1'b1);  // single cycle
        checkValue("iMemRead", 1, ctrl.iMemRead);
        checkValue("aluMode", mode, ctrl.aluMode);
        checkValue("aluSrcB", (n < 7) ? ctrlPkg::srcImm8 : ctrlPkg::srcRegB, ctrl.aluSrcB);
        checkValue("aluSrcAStatus", 0, ctrl.aluSrcAStatus);    // A from register file
        if (n < 7)
            checkValue("flagEnable", !(mode inside {4'd2, 4'd3}), ctrl.flagEnable);  // LDI
        else
            checkValue("flagEnable", mode != 4'd1, ctrl.flagEnable);
    end
endtask

task automatic testBranches();
    ctrlPkg::statusFlags_t f;
    logic [15:0]           r;
    logic [2:0]            cond;
    logic                  met;
    int                    c;
    int                    pass;
    for (c = 0; c < 8; c++) begin
        cond = 3'(c);
        f    = randFlags();
        for (pass = 0; pass < 2; pass++) begin
            if (pass == 1) f = ctrlPkg::statusFlags_t'(f ^ 4'b1110);  // other outcome
            met = condTaken(cond, f);
            r   = lcgNext();
            applyInputs({cond, r[8:0], 4'hE}, f, '0);   // relative
            checkValue("pcSrc", met ? ctrlPkg::pcBranch : ctrlPkg::pcPlusOne, ctrl.pcSrc);
            checkValue("pcWriteEn", 1, ctrl.pcWriteEn);
            applyInputs({cond, 4'h0, 9'h01F}, f, '0);   // indirect
            checkValue("pcSrc", met ? ctrlPkg::pcIndirect : ctrlPkg::pcPlusOne, ctrl.pcSrc);
            applyInputs({cond, 13'h002F}, f, '0);       // two-word jump
            if (met) begin
                checkValue("pcSrc", ctrlPkg::pcCurrent, ctrl.pcSrc);
                holdCycle();
                checkValue("pcSrc", ctrlPkg::pcFromInstr, ctrl.pcSrc);
            end else begin
                checkValue("pcSrc", ctrlPkg::pcPlusOne, ctrl.pcSrc);
            end
            checkValue("pcWriteEn", 1, ctrl.pcWriteEn);
        end
    end
endtask

task automatic testMemIo();
    ctrlPkg::instr_t word;
    logic            load;
    logic            dec;
    int              n;
    for (n = 0; n < 4; n++) begin
        load = n[1];
        dec  = n[0];
        word = {8'h56, 2'b11, load, dec, 4'hA};     // pair 6
        applyInputs(word, randFlags(), '0);
        if (load) begin
            checkStep(1'b0, 1'b0, 1'b1, 1'b0);      // read
            holdCycle();
            checkStep(1'b1, 1'b0, 1'b0, 1'b1);      // write back
            checkValue("regFileLoadMem", 1, ctrl.regFileLoadMem);
        end else begin
            checkStep(1'b1, 1'b1, 1'b0, 1'b0);
        end
        checkValue("regAdd", 1, ctrl.regAdd);
        checkValue("regConst", dec ? ctrlPkg::decConst : ctrlPkg::incConst, ctrl.regConst);
    end
    applyInputs(16'h4A08, randFlags(), '0);         // IN
    checkStep(1'b0, 1'b0, 1'b1, 1'b0);
    checkValue("dMemAddr", ctrlPkg::addrPort, ctrl.dMemAddr);
    holdCycle();
    checkStep(1'b1, 1'b0, 1'b0, 1'b1);
    applyInputs(16'h4A09, randFlags(), '0);         // OUT
    checkStep(1'b1, 1'b1, 1'b0, 1'b0);
    checkValue("dMemAddr", ctrlPkg::addrPort, ctrl.dMemAddr);
endtask

task automatic testCallRet();
    ctrlPkg::statusFlags_t f;
    f       = randFlags();
    f.carry = 1'b0;
    f.zero  = 1'b0;
    applyInputs(16'h003F, f, '0);                   // call always
    checkStep(1'b0, 1'b1, 1'b0, 1'b0);
    checkValue("dMemData", ctrlPkg::dataRetLow, ctrl.dMemData);
    checkValue("regBSelect", ctrlPkg::spLowReg, ctrl.regBSelect);
    checkValue("regAdd", 1, ctrl.regAdd);
    checkValue("regConst", ctrlPkg::decConst, ctrl.regConst);
    holdCycle();
    checkStep(1'b1, 1'b1, 1'b0, 1'b0);
    checkValue("dMemData", ctrlPkg::dataRetHigh, ctrl.dMemData);
    checkValue("regAdd", 1, ctrl.regAdd);
    checkValue("regConst", ctrlPkg::decConst, ctrl.regConst);
    checkValue("pcSrc", ctrlPkg::pcFromInstr, ctrl.pcSrc);
    applyInputs(16'h203F, f, '0);                   // call on carry is skipped
    checkStep(1'b1, 1'b0, 1'b0, 1'b0);
    checkValue("pcSrc", ctrlPkg::pcPlusOne, ctrl.pcSrc);
    applyInputs(16'h004F, f, '0);                   // ret always
    checkStep(1'b0, 1'b0, 1'b1, 1'b0);
    holdCycle();
    checkStep(1'b0, 1'b0, 1'b1, 1'b0);
    holdCycle();
    checkStep(1'b1, 1'b0, 1'b0, 1'b0);
    checkValue("pcSrc", ctrlPkg::pcFromStack, ctrl.pcSrc);
    applyInputs(16'h604F, f, '0);                   // ret on zero is skipped
    checkStep(1'b1, 1'b0, 1'b0, 1'b0);
    checkValue("pcSrc", ctrlPkg::pcPlusOne, ctrl.pcSrc);
endtask

task automatic testIrq();
    ctrlPkg::statusFlags_t f;
    logic [3:0]            reqs [4];
    int                    n;
    int                    win;
    reqs        = '{4'b1100, 4'b1010, 4'b1111, 4'b1000};
    f           = randFlags();
    f.irqEnable = 1'b1;
    for (n = 0; n < 4; n++) begin
        win = 0;
        while (!reqs[n][win]) win++;                // lowest index wins
        applyInputs(16'h0000, f, reqs[n]);          // nop gets interrupted
        checkStep(1'b0, 1'b1, 1'b0, 1'b0);
        checkValue("dMemData", ctrlPkg::dataCurLow, ctrl.dMemData);
        checkValue("irqClr", 0, irqClr);
        checkValue("irqVector", irqVectorBase + win * irqVectorStep, irqVector);
        holdCycle();
        checkStep(1'b1, 1'b1, 1'b0, 1'b0);
        checkValue("dMemData", ctrlPkg::dataCurHigh, ctrl.dMemData);
        checkValue("pcSrc", ctrlPkg::pcIrqVector, ctrl.pcSrc);
        checkValue("irqClr", 1 << win, irqClr);
    end
    f.irqEnable = 1'b0;
    applyInputs(16'h0000, f, 4'b0011);              // masked so a plain nop
    checkStep(1'b1, 1'b0, 1'b0, 1'b0);
    checkValue("pcSrc", ctrlPkg::pcPlusOne, ctrl.pcSrc);
    holdCycle();
    checkStep(1'b1, 1'b0, 1'b0, 1'b0);
    f.irqEnable = 1'b1;
    applyInputs(16'hFFFF, f, 4'b0011);              // halt takes no entry
    repeat (2) begin
        checkStep(1'b0, 1'b0, 1'b0, 1'b0);
        checkValue("irqClr", 0, irqClr);
        holdCycle();
    end
endtask

`endif

// ==== tb/controlUnit_tb.sv ====
`timescale 1ns/1ps

module controlUnit_tb;

    localparam int clkPeriod      = 10;
    localparam int resetCycles    = 10;
    localparam int startDelay     = 40;     // DUT default values
    localparam int irqVectorBase  = 20;
    localparam int irqVectorStep  = 10;
    localparam int testCount      = 6;
    localparam int maxInstrs      = 48;     // branch test runs the most words
    localparam int longestInstr   = 3;      // taken return
    localparam int watchdogCycles = resetCycles + startDelay
                                    + testCount * maxInstrs * longestInstr;

    logic                         clk;
    logic                         rst;
    ctrlPkg::instr_t              instr;
    ctrlPkg::statusFlags_t        flags;
    logic [ctrlPkg::irqCount-1:0] irqReq;
    ctrlPkg::ctrlWord_t           ctrl;
    logic [15:0]                  irqVector;
    logic [ctrlPkg::irqCount-1:0] irqClr;
    logic [31:0]                  lcgState;     // random state
    int                           errorCount;

    controlUnit #(
        .startDelay    (startDelay),
        .irqVectorBase (irqVectorBase),
        .irqVectorStep (irqVectorStep)
    ) i_controlUnit (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .flags     (flags),
        .irqReq    (irqReq),
        .ctrl      (ctrl),
        .irqVector (irqVector),
        .irqClr    (irqClr)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);      // all tests plus margin
        $display("Errors found");
        $fatal(1, "Timeout: the tests did not finish within %0d cycles", watchdogCycles);
    end

    // **************************************************
    // helpers
    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];         // upper bits, better spread
    endfunction

    function automatic ctrlPkg::statusFlags_t randFlags();
        logic [15:0]           r;
        ctrlPkg::statusFlags_t f;
        r           = lcgNext();
        f           = ctrlPkg::statusFlags_t'(r[3:0]);
        f.irqEnable = 1'b0;             // interrupts only where wanted
        return f;
    endfunction

    // branch condition table
    function automatic logic condTaken(input logic [2:0] cond, input ctrlPkg::statusFlags_t f);
        case (cond)
            3'd1:    return f.carry;
            3'd2:    return !f.carry;
            3'd3:    return f.zero;
            3'd4:    return !f.zero;
            3'd5:    return f.negative;
            3'd6:    return !f.negative;
            default: return 1'b1;       // 0 and 7 always
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // the four strobes of one step
    task automatic checkStep(input logic pcWrite, input logic memWrite, input logic memRead,
                             input logic regWrite);
        checkValue("pcWriteEn", pcWrite, ctrl.pcWriteEn);
        checkValue("dMemWrite", memWrite, ctrl.dMemWrite);
        checkValue("dMemRead", memRead, ctrl.dMemRead);
        checkValue("regWrite", regWrite, ctrl.regWrite);
    endtask

    // new word on the falling edge, look after it settles
    task automatic applyInputs(input ctrlPkg::instr_t word, input ctrlPkg::statusFlags_t f,
                               input logic [ctrlPkg::irqCount-1:0] req);
        @(negedge clk);
        instr  = word;
        flags  = f;
        irqReq = req;
        #1;
    endtask

    task automatic holdCycle();
        @(negedge clk);                 // inputs unchanged
        #1;
    endtask

    `include "controlUnit_tests.svh"

    // **************************************************
    // test sequence
    initial begin
        rst        = 1'b1;
        instr      = '0;
        flags      = '0;
        irqReq     = '0;
        lcgState   = 32'd68;            // seed
        errorCount = 0;
        testStartDelay();
        testAluOps();
        testBranches();
        testMemIo();
        testCallRet();
        testIrq();
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb/controlUnit_sva.sv ====
`timescale 1ns/1ps

module controlUnit_sva (
    input logic                         clk,
    input logic                         rst,
    input ctrlPkg::ctrlWord_t           ctrl,
    input logic [ctrlPkg::irqCount-1:0] irqClr
);

    // **************************************************
    // control word rules
    irqClrOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(irqClr))
        else $error("irqClr has more than one line set");

    memNotBoth: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.dMemWrite && ctrl.dMemRead))     // one data access per cycle
        else $error("dMemWrite and dMemRead high together");

    clrWithFetch: assert property (@(posedge clk) disable iff (rst)
        (|irqClr) |-> ctrl.pcWriteEn)           // clear only on the vector jump
        else $error("irqClr pulsed without pcWriteEn");

endmodule

bind controlUnit controlUnit_sva i_controlUnit_sva (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .irqClr (irqClr)
);

// ==== control/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit #(
    parameter int startDelay    = 40,   // cycles held in stStart
    parameter int irqVectorBase = 20,
    parameter int irqVectorStep = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    input  ctrlPkg::instr_t               instr,
    input  ctrlPkg::statusFlags_t         flags,
    input  logic [ctrlPkg::irqCount-1:0]  irqReq,
    output ctrlPkg::ctrlWord_t            ctrl,
    output logic [15:0]                   irqVector,
    output logic [ctrlPkg::irqCount-1:0]  irqClr
);

    ctrlPkg::decodedInstr_t decoded;
    ctrlPkg::seqState_e     state;
    logic                   uninterruptible;
    logic                   irqPending;
    logic                   irqTake;    // high in stIrq
    logic                   irqEntry;   // accept decision in stPart1
    logic                   startDone;

    instrDecoder i_instrDecoder (
        .instr           (instr),
        .flags           (flags),
        .decoded         (decoded),
        .uninterruptible (uninterruptible)
    );

    irqArbiter #(
        .irqVectorBase (irqVectorBase),
        .irqVectorStep (irqVectorStep)
    ) i_irqArbiter (
        .irqReq     (irqReq),
        .irqTake    (irqTake),
        .irqPending (irqPending),
        .irqVector  (irqVector),
        .irqClr     (irqClr)
    );

    stepSequencer #(
        .startDelay (startDelay)
    ) i_stepSequencer (
        .clk             (clk),
        .rst             (rst),
        .decoded         (decoded),
        .uninterruptible (uninterruptible),
        .irqPending      (irqPending),
        .irqEnable       (flags.irqEnable),
        .state           (state),
        .startDone       (startDone),
        .irqEntry        (irqEntry),
        .irqTake         (irqTake)
    );

    controlWordGen i_controlWordGen (
        .state     (state),
        .startDone (startDone),
        .irqEntry  (irqEntry),
        .decoded   (decoded),
        .ctrl      (ctrl)
    );

endmodule

// ==== control/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen (
    input  ctrlPkg::seqState_e     state,
    input  logic                   startDone,
    input  logic                   irqEntry,
    input  ctrlPkg::decodedInstr_t decoded,
    output ctrlPkg::ctrlWord_t     ctrl
);

    logic part1;
    logic part2;
    logic part3;

    assign part1 = (state == ctrlPkg::stPart1);
    assign part2 = (state == ctrlPkg::stPart2);
    assign part3 = (state == ctrlPkg::stPart3);

    always_comb begin
        // **************************************************
        // default: one cycle, nothing written, advance pc
        ctrl                = '0;
        ctrl.regBSelect     = decoded.regB;
        ctrl.aluSrcB        = ctrlPkg::srcRegB;
        ctrl.dMemData       = ctrlPkg::dataAlu;
        ctrl.dMemAddr       = ctrlPkg::addrPtr;
        ctrl.statusSrc      = ctrlPkg::statAluFlags;
        ctrl.pcSrc          = ctrlPkg::pcPlusOne;
        ctrl.iMemRead       = 1'b1;
        ctrl.pcWriteEn      = 1'b1;

        if (state == ctrlPkg::stStart) begin
            ctrl.statusSrc  = ctrlPkg::statIrqOff;  // keep interrupts off while waiting
            ctrl.flagEnable = 1'b1;
            ctrl.pcWriteEn  = startDone;            // first fetch
        end else if (irqEntry) begin
            ctrl.regBSelect = ctrlPkg::spLowReg;    // push low byte, sp--
            ctrl.regAdd     = 1'b1;
            ctrl.regConst   = ctrlPkg::decConst;
            ctrl.dMemData   = ctrlPkg::dataCurLow;
            ctrl.dMemWrite  = 1'b1;
            ctrl.statusSrc  = ctrlPkg::statIrqOff;
            ctrl.flagEnable = 1'b1;
            ctrl.pcSrc      = ctrlPkg::pcIrqVector;
            ctrl.iMemRead   = 1'b0;                 // jump happens next step
            ctrl.pcWriteEn  = 1'b0;
        end else begin
            case (state)
                ctrlPkg::stIrq: begin
                    ctrl.regBSelect = ctrlPkg::spLowReg;    // push high byte, sp--
                    ctrl.regAdd     = 1'b1;
                    ctrl.regConst   = ctrlPkg::decConst;
                    ctrl.dMemData   = ctrlPkg::dataCurHigh;
                    ctrl.dMemWrite  = 1'b1;
                    ctrl.statusSrc  = ctrlPkg::statIrqOff;
                    ctrl.flagEnable = 1'b1;
                    ctrl.pcSrc      = ctrlPkg::pcIrqVector;
                end
                ctrlPkg::stJump: ctrl.pcSrc = ctrlPkg::pcFromInstr;   // address word
                ctrlPkg::stCall: begin
                    ctrl.regBSelect = ctrlPkg::spLowReg;
                    ctrl.regAdd     = 1'b1;
                    ctrl.regConst   = ctrlPkg::decConst;
                    ctrl.dMemData   = ctrlPkg::dataRetHigh; // return addr msbs
                    ctrl.dMemWrite  = 1'b1;
                    ctrl.pcSrc      = ctrlPkg::pcFromInstr;
                end
                default: begin
                    // **************************************************
                    // part 1..3 steps per class
                    case (decoded.cls)
                        ctrlPkg::clsRegImm: begin
                            ctrl.regWrite   = 1'b1;
                            ctrl.aluSrcB    = ctrlPkg::srcImm8;
                            ctrl.aluMode    = decoded.aluMode;
                            ctrl.flagEnable = (decoded.aluMode[2:1] != 2'b01);  // not LDI
                        end
                        ctrlPkg::clsRegReg,
                        ctrlPkg::clsRegOnly: begin
                            ctrl.regWrite   = 1'b1;
                            ctrl.aluMode    = decoded.aluMode;
                            ctrl.flagEnable = (decoded.aluMode != 4'b0001); // MOV keeps flags
                        end
                        ctrlPkg::clsIo: begin
                            ctrl.regFileLoadMem = 1'b1;
                            ctrl.regWrite       = part2;
                            ctrl.dMemAddr       = ctrlPkg::addrPort;    // imm port number
                            ctrl.dMemWrite      = decoded.dirBit;
                            ctrl.dMemRead       = !decoded.dirBit && part1;
                            ctrl.pcWriteEn      = decoded.dirBit || part2;
                            ctrl.iMemRead       = decoded.dirBit || part2;
                        end
                        ctrlPkg::clsPtrMem: begin
                            ctrl.regFileLoadMem = 1'b1;
                            ctrl.regWrite       = !decoded.dirBit && part2;
                            ctrl.regAdd         = decoded.dirBit || part2;  // step pointer once
                            ctrl.regConst       = decoded.aluMode[0] ? ctrlPkg::decConst
                                                                     : ctrlPkg::incConst;
                            ctrl.dMemWrite      = decoded.dirBit;
                            ctrl.dMemRead       = !decoded.dirBit && part1;
                            ctrl.pcWriteEn      = decoded.dirBit || part2;
                            ctrl.iMemRead       = decoded.dirBit || part2;
                        end
                        ctrlPkg::clsBranch: begin
                            if (decoded.condMet) begin
                                ctrl.pcSrc = decoded.dirBit ? ctrlPkg::pcIndirect
                                                            : ctrlPkg::pcBranch;
                            end
                        end
                        ctrlPkg::clsJump: begin     // taken: fetch address word
                            if (decoded.condMet) ctrl.pcSrc = ctrlPkg::pcCurrent;
                        end
                        ctrlPkg::clsCall: begin
                            ctrl.regBSelect = ctrlPkg::spLowReg;
                            ctrl.regAdd     = decoded.condMet;
                            ctrl.regConst   = ctrlPkg::decConst;
                            ctrl.dMemData   = ctrlPkg::dataRetLow;  // lsbs first
                            ctrl.dMemWrite  = decoded.condMet;
                            ctrl.pcWriteEn  = !decoded.condMet;     // pc held for msbs
                            if (decoded.condMet) ctrl.pcSrc = ctrlPkg::pcCurrent;
                        end
                        ctrlPkg::clsRet: begin
                            ctrl.regBSelect = ctrlPkg::spLowReg;    // pop via sp+1
                            ctrl.regAdd     = (part1 && decoded.condMet) || part2;
                            ctrl.regConst   = ctrlPkg::incConst;
                            ctrl.dMemAddr   = ctrlPkg::addrPtrPlusOne;
                            ctrl.dMemRead   = (part1 && decoded.condMet) || part2;
                            ctrl.pcSrc      = part1 ? ctrlPkg::pcPlusOne : ctrlPkg::pcFromStack;
                            ctrl.pcWriteEn  = (part1 && !decoded.condMet) || part3;
                            ctrl.iMemRead   = (part1 && !decoded.condMet) || part3;
                        end
                        ctrlPkg::clsHalt: begin     // sits here forever
                            ctrl.pcWriteEn = 1'b0;
                            ctrl.iMemRead  = 1'b0;
                        end
                        default: ctrl.pcWriteEn = 1'b1; // nop, illegal: skip
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== control/stepSequencer.sv ====
`timescale 1ns/1ps

module stepSequencer #(
    parameter int startDelay = 40
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ctrlPkg::decodedInstr_t decoded,
    input  logic                   uninterruptible,
    input  logic                   irqPending,
    input  logic                   irqEnable,
    output ctrlPkg::seqState_e     state,
    output logic                   startDone,
    output logic                   irqEntry,
    output logic                   irqTake
);

    localparam int cntW = $clog2(startDelay + 1);

    ctrlPkg::seqState_e nextState;
    logic [cntW-1:0]    delayCnt;   // counts only while in stStart

    // **************************************************
    // state and start delay registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ctrlPkg::stStart;
            delayCnt <= '0;
        end else begin
            state    <= nextState;
            delayCnt <= (state == ctrlPkg::stStart && !startDone) ? delayCnt + 1'b1 : '0;
        end
    end

    assign startDone = (state == ctrlPkg::stStart) && (delayCnt == cntW'(startDelay));
    assign irqEntry  = (state == ctrlPkg::stPart1) && irqEnable && irqPending
                       && !uninterruptible;     // halt is never interrupted
    assign irqTake   = (state == ctrlPkg::stIrq);

    // **************************************************
    // next step
    always_comb begin
        nextState = ctrlPkg::stPart1;   // most steps end the instruction
        case (state)
            ctrlPkg::stStart: nextState = startDone ? ctrlPkg::stPart1 : ctrlPkg::stStart;
            ctrlPkg::stPart1: begin
                if (irqEntry) begin
                    nextState = ctrlPkg::stIrq;     // second push + vector
                end else begin
                    case (decoded.cls)
                        ctrlPkg::clsIo,
                        ctrlPkg::clsPtrMem: begin   // reads take a second cycle
                            if (!decoded.dirBit) nextState = ctrlPkg::stPart2;
                        end
                        ctrlPkg::clsJump: begin
                            if (decoded.condMet) nextState = ctrlPkg::stJump;
                        end
                        ctrlPkg::clsCall: begin
                            if (decoded.condMet) nextState = ctrlPkg::stCall;
                        end
                        ctrlPkg::clsRet: begin
                            if (decoded.condMet) nextState = ctrlPkg::stPart2;
                        end
                        default: nextState = ctrlPkg::stPart1;
                    endcase
                end
            end
            ctrlPkg::stPart2: begin   // only ret has a third step
                if (decoded.cls == ctrlPkg::clsRet) nextState = ctrlPkg::stPart3;
            end
            default: nextState = ctrlPkg::stPart1;
        endcase
    end

endmodule

// ==== logic/irqArbiter.sv ====
`timescale 1ns/1ps

module irqArbiter #(
    parameter int irqVectorBase = 20,
    parameter int irqVectorStep = 10
) (
    input  logic [ctrlPkg::irqCount-1:0] irqReq,
    input  logic                         irqTake,
    output logic                         irqPending,
    output logic [15:0]                  irqVector,
    output logic [ctrlPkg::irqCount-1:0] irqClr
);

    localparam int idxW = $clog2(ctrlPkg::irqCount);

    logic [idxW-1:0]              winIdx;
    logic [ctrlPkg::irqCount-1:0] winOneHot;

    // scan from the top so the lowest active index ends up winning
    always_comb begin
        winIdx    = '0;
        winOneHot = '0;
        for (int i = ctrlPkg::irqCount - 1; i >= 0; i--) begin
            if (irqReq[i]) begin
                winIdx    = idxW'(i);
                winOneHot = ctrlPkg::irqCount'(1) << i;
            end
        end
    end

    assign irqPending = |irqReq;
    assign irqVector  = irqPending ? 16'(irqVectorBase + int'(winIdx) * irqVectorStep)
                                   : 16'd0;    // no request, no vector
    assign irqClr     = irqTake ? winOneHot : '0;  // clear pulse in stIrq only

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  ctrlPkg::instr_t        instr,
    input  ctrlPkg::statusFlags_t  flags,
    output ctrlPkg::decodedInstr_t decoded,
    output logic                   uninterruptible
);

    ctrlPkg::condCode_e cond;

    assign cond = ctrlPkg::condCode_e'(instr[15:13]);

    // **************************************************
    // class, first match wins
    always_comb begin
        if (instr[3:0] >= 4'h1 && instr[3:0] <= 4'h7)
            decoded.cls = ctrlPkg::clsRegImm;
        else if (instr[3:1] == 3'b100)                                  // 8 in, 9 out
            decoded.cls = ctrlPkg::clsIo;
        else if (instr[3:0] == 4'hA && instr[7:4] >= 4'h1 && instr[7:4] <= 4'h9)
            decoded.cls = ctrlPkg::clsRegReg;
        else if (instr[3:0] == 4'hF && instr[7:4] >= 4'hA && instr[11:8] == 4'h0)
            decoded.cls = ctrlPkg::clsRegOnly;
        else if (instr[3:0] == 4'hA && instr[7:4] >= 4'hC && !instr[8])
            decoded.cls = ctrlPkg::clsPtrMem;
        else if (instr[3:0] == 4'hE || (instr[8:0] == 9'h01F && !instr[12]))
            decoded.cls = ctrlPkg::clsBranch;
        else if (instr[12:0] == 13'h002F)
            decoded.cls = ctrlPkg::clsJump;
        else if (instr[12:0] == 13'h003F)
            decoded.cls = ctrlPkg::clsCall;
        else if (instr[12:0] == 13'h004F)
            decoded.cls = ctrlPkg::clsRet;
        else if (instr == 16'h0000)
            decoded.cls = ctrlPkg::clsNop;
        else if (instr == 16'hFFFF)
            decoded.cls = ctrlPkg::clsHalt;
        else
            decoded.cls = ctrlPkg::clsIllegal;
    end

    // **************************************************
    // fields
    always_comb begin
        case (decoded.cls)
            ctrlPkg::clsRegImm: decoded.aluMode = {1'b0, instr[2:0]};
            ctrlPkg::clsPtrMem: decoded.aluMode = {3'b000, instr[4]};   // post-dec select
            default:            decoded.aluMode = instr[6:3];
        endcase
        if (decoded.cls inside {ctrlPkg::clsRegReg, ctrlPkg::clsRegOnly, ctrlPkg::clsPtrMem})
            decoded.regB = instr[11:8];     // source or pointer pair
        else
            decoded.regB = instr[15:12];
        // store when bit5 low, otherwise bit0 (out / indirect)
        decoded.dirBit = (decoded.cls == ctrlPkg::clsPtrMem) ? !instr[5] : instr[0];
    end

    always_comb begin
        case (cond)
            ctrlPkg::condCarrySet: decoded.condMet = flags.carry;
            ctrlPkg::condCarryClr: decoded.condMet = !flags.carry;
            ctrlPkg::condZeroSet:  decoded.condMet = flags.zero;
            ctrlPkg::condZeroClr:  decoded.condMet = !flags.zero;
            ctrlPkg::condNegSet:   decoded.condMet = flags.negative;
            ctrlPkg::condNegClr:   decoded.condMet = !flags.negative;
            default:               decoded.condMet = 1'b1;   // both always codes
        endcase
    end

    assign uninterruptible = (decoded.cls == ctrlPkg::clsHalt);

endmodule

// ==== common/ctrlPkg.sv ====
package ctrlPkg;

    // **************************************************
    // widths and constants
    localparam int instrWidth = 16;                     // instruction word
    localparam int dataWidth  = 8;                      // datapath bytes
    localparam int irqCount   = 4;                      // request lines, 0 wins
    localparam logic [3:0] spLowReg = 4'd14;            // low stack pointer byte
    localparam logic [dataWidth-1:0] incConst = 8'd1;   // post-increment / pop
    localparam logic [dataWidth-1:0] decConst = 8'd255; // post-decrement / push

    typedef logic [instrWidth-1:0] instr_t;

    // **************************************************
    // encodings
    typedef enum logic [3:0] {
        clsRegImm,                  // alu op with imm8, LDI too
        clsIo,                      // IN / OUT
        clsRegReg,                  // two register alu op
        clsRegOnly,                 // single register alu op
        clsPtrMem,                  // pointer load / store
        clsBranch,                  // relative branch or indirect jump
        clsJump,
        clsCall,
        clsRet,
        clsNop,
        clsHalt,
        clsIllegal
    } instrClass_e;

    typedef enum logic [2:0] {
        condAlways, condCarrySet, condCarryClr, condZeroSet,
        condZeroClr, condNegSet, condNegClr, condAlwaysAlt
    } condCode_e;

    typedef enum logic [2:0] {
        stPart1, stPart2, stPart3, stJump, stCall, stIrq, stStart
    } seqState_e;

    typedef enum logic [2:0] {
        pcCurrent, pcPlusOne, pcIrqVector, pcFromInstr, pcBranch, pcFromStack, pcIndirect
    } pcSrc_e;

    typedef enum logic [2:0] {
        dataAlu, dataRetHigh, dataRetLow, dataCurHigh, dataCurLow
    } dMemData_e;

    typedef enum logic [1:0] {
        addrPtr, addrPort, addrPtrPlusOne
    } dMemAddr_e;

    typedef enum logic [1:0] {
        srcRegB, srcMask4, srcImm8
    } aluSrcB_e;

    typedef enum logic [1:0] {
        statAluFlags, statAluOut, statMem, statIrqOff
    } statusSrc_e;

    // **************************************************
    // bundles
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic irqEnable;
    } statusFlags_t;

    typedef struct packed {
        instrClass_e cls;
        logic        condMet;       // condition field vs flags
        logic        dirBit;        // store / out / indirect
        logic [3:0]  aluMode;       // ptr class: bit0 is post-decrement
        logic [3:0]  regB;
    } decodedInstr_t;

    typedef struct packed {
        logic                 regFileLoadMem;   // reg write data from memory
        logic [3:0]           regBSelect;
        logic                 regWrite;
        logic                 regAdd;           // add regConst to pair
        logic [dataWidth-1:0] regConst;
        logic                 aluSrcAStatus;
        aluSrcB_e             aluSrcB;
        logic [3:0]           aluMode;
        dMemData_e            dMemData;
        dMemAddr_e            dMemAddr;
        logic                 dMemWrite;
        logic                 dMemRead;
        statusSrc_e           statusSrc;
        logic                 flagEnable;
        pcSrc_e               pcSrc;
        logic                 iMemRead;
        logic                 pcWriteEn;
    } ctrlWord_t;

endpackage
